/* hw/cu_defs.svh */
`ifndef CU_DEFS_SVH
`define CU_DEFS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Host addresses are byte addresses
`define CU_ADDR_BITS 64

// Line counters and array sizes
`define CU_COUNT_BITS 32

// Tag is the line index modulo 256
`define CU_TAG_BITS 8

// One data line as seen on the bus
`define CU_DATA_BITS 64

//////////////////////////////
// Memory layout and buffering
//////////////////////////////

// Address step between consecutive lines
`define CU_LINE_BYTES 128

// Entries in the read data queue
`define CU_FIFO_DEPTH 8

`endif

/* hw/cu_pkg.sv */
`include "cu_defs.svh"

package cu_pkg;

	//////////////////////////////
	// Command kinds
	//////////////////////////////

	typedef enum logic [1:0] {
		CMD_NONE  = 2'd0,
		CMD_READ  = 2'd1,
		CMD_WRITE = 2'd2
	} cmd_kind_e;

	//////////////////////////////
	// Host side records
	//////////////////////////////

	// Work descriptor, sizes in cache lines
	typedef struct packed {
		logic                        valid;
		logic [`CU_ADDR_BITS-1:0]    array_send;
		logic [`CU_ADDR_BITS-1:0]    array_receive;
		logic [`CU_COUNT_BITS-1:0]   size_send;
		logic [`CU_COUNT_BITS-1:0]   size_receive;
	} wed_t;

	typedef struct packed {
		logic                        valid;
		cmd_kind_e                   kind;
		logic [`CU_ADDR_BITS-1:0]    address;
		logic [`CU_TAG_BITS-1:0]     tag;
	} command_t;

	// Completion of one command
	typedef struct packed {
		logic                        valid;
		logic [`CU_TAG_BITS-1:0]     tag;
	} response_t;

	typedef struct packed {
		logic                        valid;
		logic [`CU_TAG_BITS-1:0]     tag;
		logic [`CU_DATA_BITS-1:0]    data;
	} data_line_t;

	// Level from a command buffer, not a strobe
	typedef struct packed {
		logic                        almost_full;
	} buffer_status_t;

endpackage

/* hw/cu_input_stage.sv */
`timescale 1ns/1ps

module cu_input_stage import cu_pkg::*; (
	input  logic        clock,
	input  logic        rstn,
	input  logic        enabled_in,
	input  logic [63:0] cu_configure,
	input  wed_t        wed_request_in,
	input  response_t   read_response_in,
	input  response_t   write_response_in,
	input  data_line_t  read_data_in,
	output logic        enabled,
	output logic        engine_enabled,
	output logic        cu_ready,
	output wed_t        wed,
	output logic [63:0] configure,
	output response_t   read_response,
	output response_t   write_response,
	output data_line_t  read_data
);

	//////////////////////////////
	// Enable
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled        <= 1'b0;
			engine_enabled <= 1'b0;
		end else begin
			enabled        <= enabled_in;
			// Engines follow the unit enable one cycle later
			engine_enabled <= enabled & cu_ready;
		end
	end

	// Needs a job and a non-zero configuration
	assign cu_ready = (|configure) && wed.valid;

	//////////////////////////////
	// Input registers
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed            <= '0;
			configure      <= '0;
			read_response  <= '0;
			write_response <= '0;
			read_data      <= '0;
		end else if (enabled) begin
			// Descriptor is held once taken
			if (wed_request_in.valid)
				wed <= wed_request_in;
			if (|cu_configure)
				configure <= cu_configure;
			read_response  <= read_response_in;
			write_response <= write_response_in;
			read_data      <= read_data_in;
		end else begin
			// Payload holds, strobes end after one cycle
			read_response.valid  <= 1'b0;
			write_response.valid <= 1'b0;
			read_data.valid      <= 1'b0;
		end
	end

endmodule

/* hw/cu_read_engine.sv */
`timescale 1ns/1ps
`include "cu_defs.svh"

module cu_read_engine import cu_pkg::*; #(
	parameter int FREE_BITS = $clog2(`CU_FIFO_DEPTH + 1)
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      engine_enabled,
	input  wed_t                      wed,
	input  buffer_status_t            read_buffer_status,
	input  logic [FREE_BITS-1:0]      fifo_free,
	input  response_t                 read_response,
	output command_t                  read_command,
	output logic [`CU_COUNT_BITS-1:0] read_count
);

	logic [`CU_COUNT_BITS-1:0] line_index;
	logic [`CU_COUNT_BITS-1:0] in_flight;
	logic [`CU_TAG_BITS-1:0]   line_tag;
	logic                      issue;

	//////////////////////////////
	// Issue decision
	//////////////////////////////

	assign line_tag = line_index[`CU_TAG_BITS-1:0];

	// Reads sent whose data has not come back yet
	assign in_flight = line_index - read_count;

	// Every outstanding read must find a free queue slot, plus two of margin
	assign issue = engine_enabled && wed.valid
		&& (line_index < wed.size_send)
		&& !read_buffer_status.almost_full
		&& (`CU_COUNT_BITS'(fifo_free) >= in_flight + 2);

	//////////////////////////////
	// Line index
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			line_index <= '0;
		end else if (issue) begin
			line_index <= line_index + 1'b1;
		end
	end

	//////////////////////////////
	// Command register
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command <= '0;
		end else begin
			read_command.valid <= issue;
			if (issue) begin
				read_command.kind    <= CMD_READ;
				read_command.address <= wed.array_send
					+ `CU_ADDR_BITS'(line_tag) * `CU_LINE_BYTES;
				read_command.tag     <= line_tag;
			end
		end
	end

	//////////////////////////////
	// Completion count
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_count <= '0;
		end else if (read_response.valid) begin
			read_count <= read_count + 1'b1;
		end
	end

endmodule

/* hw/cu_data_fifo.sv */
`timescale 1ns/1ps
`include "cu_defs.svh"

module cu_data_fifo import cu_pkg::*; #(
	parameter int FREE_BITS = $clog2(`CU_FIFO_DEPTH + 1)
) (
	input  logic                 clock,
	input  logic                 rstn,
	input  data_line_t           push_line,
	input  logic                 pop,
	output data_line_t           head,
	output logic [FREE_BITS-1:0] fifo_free
);

	localparam int PTR_BITS = $clog2(`CU_FIFO_DEPTH);

	data_line_t           entries [`CU_FIFO_DEPTH];
	logic [PTR_BITS-1:0]  wr_ptr;
	logic [PTR_BITS-1:0]  rd_ptr;
	logic [FREE_BITS-1:0] fill;
	logic                 do_push;
	logic                 do_pop;

	assign do_push = push_line.valid && (fill != FREE_BITS'(`CU_FIFO_DEPTH));
	assign do_pop  = pop && (fill != '0);

	//////////////////////////////
	// Storage
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (do_push)
			entries[wr_ptr] <= push_line;
	end

	// Pointers wrap on the power of two depth
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			fill <= fill + FREE_BITS'(do_push) - FREE_BITS'(do_pop);
		end
	end

	//////////////////////////////
	// Head and free space
	//////////////////////////////

	always_comb begin
		head       = entries[rd_ptr];
		head.valid = (fill != '0);
	end

	assign fifo_free = FREE_BITS'(`CU_FIFO_DEPTH) - fill;

endmodule

/* hw/cu_write_engine.sv */
`timescale 1ns/1ps
`include "cu_defs.svh"

module cu_write_engine import cu_pkg::*; (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      engine_enabled,
	input  wed_t                      wed,
	input  buffer_status_t            write_buffer_status,
	input  data_line_t                head,
	output logic                      pop,
	input  response_t                 write_response,
	output command_t                  write_command,
	output data_line_t                write_data,
	output logic [`CU_COUNT_BITS-1:0] write_count
);

	logic [`CU_ADDR_BITS-1:0] dest_address;

	//////////////////////////////
	// Pop decision
	//////////////////////////////

	// One line per cycle while the write buffer has room
	assign pop = head.valid && engine_enabled && !write_buffer_status.almost_full;

	// Same line index as the source, in the destination array
	assign dest_address = wed.array_receive
		+ `CU_ADDR_BITS'(head.tag) * `CU_LINE_BYTES;

	//////////////////////////////
	// Command and data registers
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_command <= '0;
		end else begin
			write_command.valid <= pop;
			if (pop) begin
				write_command.kind    <= CMD_WRITE;
				write_command.address <= dest_address;
				write_command.tag     <= head.tag;
			end
		end
	end

	// Data leaves in the same cycle as its command
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_data <= '0;
		end else begin
			write_data.valid <= pop;
			if (pop) begin
				write_data.tag  <= head.tag;
				write_data.data <= head.data;
			end
		end
	end

	//////////////////////////////
	// Completion count
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_count <= '0;
		end else if (write_response.valid) begin
			write_count <= write_count + 1'b1;
		end
	end

endmodule

/* hw/cu_output_stage.sv */
`timescale 1ns/1ps
`include "cu_defs.svh"

module cu_output_stage import cu_pkg::*; (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enabled,
	input  logic                      cu_ready,
	input  wed_t                      wed,
	input  logic [`CU_COUNT_BITS-1:0] read_count,
	input  logic [`CU_COUNT_BITS-1:0] write_count,
	input  command_t                  read_command,
	input  command_t                  write_command,
	input  data_line_t                write_data,
	output command_t                  read_command_out,
	output command_t                  write_command_out,
	output data_line_t                write_data_out,
	output logic [63:0]               cu_return,
	output logic                      cu_done,
	output logic                      cu_status
);

	logic        done_next;
	logic [63:0] return_next;

	//////////////////////////////
	// Completion
	//////////////////////////////

	assign done_next = wed.valid
		&& (read_count == wed.size_send)
		&& (write_count == wed.size_receive);

	// Writes in the upper half, reads in the lower
	assign return_next = wed.valid ? {write_count, read_count} : '0;

	//////////////////////////////
	// Output registers
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_out  <= '0;
			write_command_out <= '0;
			write_data_out    <= '0;
			cu_return         <= '0;
			cu_done           <= 1'b0;
			cu_status         <= 1'b0;
		end else if (enabled) begin
			read_command_out  <= read_command;
			write_command_out <= write_command;
			write_data_out    <= write_data;
			cu_return         <= return_next;
			cu_done           <= done_next;
			cu_status         <= cu_ready;
		end else begin
			// Values hold while paused and no strobe repeats
			read_command_out.valid  <= 1'b0;
			write_command_out.valid <= 1'b0;
			write_data_out.valid    <= 1'b0;
		end
	end

endmodule

/* hw/cu_control.sv */
`timescale 1ns/1ps
`include "cu_defs.svh"

module cu_control import cu_pkg::*; (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled_in,
	input  logic [63:0]    cu_configure,
	input  wed_t           wed_request_in,
	input  response_t      read_response_in,
	input  response_t      write_response_in,
	input  data_line_t     read_data_in,
	input  buffer_status_t read_buffer_status,
	input  buffer_status_t write_buffer_status,
	output command_t       read_command_out,
	output command_t       write_command_out,
	output data_line_t     write_data_out,
	output logic [63:0]    cu_return,
	output logic           cu_done,
	output logic           cu_status
);

	localparam int FREE_BITS = $clog2(`CU_FIFO_DEPTH + 1);

	logic                      enabled;
	logic                      engine_enabled;
	logic                      cu_ready;
	wed_t                      wed;
	response_t                 read_response;
	response_t                 write_response;
	data_line_t                read_data;
	command_t                  read_command;
	command_t                  write_command;
	data_line_t                write_data;
	logic [`CU_COUNT_BITS-1:0] read_count;
	logic [`CU_COUNT_BITS-1:0] write_count;
	logic [FREE_BITS-1:0]      fifo_free;
	data_line_t                fifo_head;
	logic                      fifo_pop;

	//////////////////////////////
	// Input capture
	//////////////////////////////

	cu_input_stage i_input_stage (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.cu_configure      (cu_configure),
		.wed_request_in    (wed_request_in),
		.read_response_in  (read_response_in),
		.write_response_in (write_response_in),
		.read_data_in      (read_data_in),
		.enabled           (enabled),
		.engine_enabled    (engine_enabled),
		.cu_ready          (cu_ready),
		.wed               (wed),
		.configure         (),
		.read_response     (read_response),
		.write_response    (write_response),
		.read_data         (read_data)
	);

	//////////////////////////////
	// Engines and data queue
	//////////////////////////////

	cu_read_engine #(.FREE_BITS(FREE_BITS)) i_read_engine (
		.clock              (clock),
		.rstn               (rstn),
		.engine_enabled     (engine_enabled),
		.wed                (wed),
		.read_buffer_status (read_buffer_status),
		.fifo_free          (fifo_free),
		.read_response      (read_response),
		.read_command       (read_command),
		.read_count         (read_count)
	);

	cu_data_fifo #(.FREE_BITS(FREE_BITS)) i_data_fifo (
		.clock     (clock),
		.rstn      (rstn),
		.push_line (read_data),
		.pop       (fifo_pop),
		.head      (fifo_head),
		.fifo_free (fifo_free)
	);

	cu_write_engine i_write_engine (
		.clock               (clock),
		.rstn                (rstn),
		.engine_enabled      (engine_enabled),
		.wed                 (wed),
		.write_buffer_status (write_buffer_status),
		.head                (fifo_head),
		.pop                 (fifo_pop),
		.write_response      (write_response),
		.write_command       (write_command),
		.write_data          (write_data),
		.write_count         (write_count)
	);

	//////////////////////////////
	// Output stage
	//////////////////////////////

	cu_output_stage i_output_stage (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.cu_ready          (cu_ready),
		.wed               (wed),
		.read_count        (read_count),
		.write_count       (write_count),
		.read_command      (read_command),
		.write_command     (write_command),
		.write_data        (write_data),
		.read_command_out  (read_command_out),
		.write_command_out (write_command_out),
		.write_data_out    (write_data_out),
		.cu_return         (cu_return),
		.cu_done           (cu_done),
		.cu_status         (cu_status)
	);

endmodule

/* bench/cu_memory_model.sv */
`timescale 1ns/1ps
`include "cu_defs.svh"

module cu_memory_model import cu_pkg::*; #(
	parameter logic [31:0] SEED     = 32'd1,
	parameter logic [63:0] DATA_KEY = '0
) (
	input  logic       clock,
	input  logic       rstn,
	input  logic       enabled_in,
	input  command_t   read_command,
	input  command_t   write_command,
	input  data_line_t write_data,
	output response_t  read_response,
	output response_t  write_response,
	output data_line_t read_data
);

	logic [31:0]              rng;
	logic                     host_sees_enable;
	int                       now;
	int                       rd_due [$];
	logic [`CU_TAG_BITS-1:0]  rd_tag [$];
	logic [`CU_DATA_BITS-1:0] rd_val [$];
	int                       wr_due [$];
	logic [`CU_TAG_BITS-1:0]  wr_tag [$];

	// Per line records, indexed by tag
	logic [`CU_ADDR_BITS-1:0] rd_addr [256];
	logic [`CU_ADDR_BITS-1:0] wr_addr [256];
	logic [`CU_DATA_BITS-1:0] wr_data [256];
	int                       rd_hits [256];
	int                       wr_hits [256];
	int                       rd_total;
	int                       wr_total;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Host latency of 1 to 6 cycles
	task automatic draw_delay(output int d);
		rng = xorshift(rng);
		d   = 1 + int'(rng % 32'd6);
	endtask

	task automatic clear_state();
		rd_due.delete();
		rd_tag.delete();
		rd_val.delete();
		wr_due.delete();
		wr_tag.delete();
		for (int i = 0; i < 256; i++) begin
			rd_addr[i] = '0;
			wr_addr[i] = '0;
			wr_data[i] = '0;
			rd_hits[i] = 0;
			wr_hits[i] = 0;
		end
		rd_total = 0;
		wr_total = 0;
	endtask

	task automatic accept_commands();
		int d;
		if (read_command.valid) begin
			draw_delay(d);
			rd_due.push_back(now + d);
			rd_tag.push_back(read_command.tag);
			// Source line content is its address scrambled by a key
			rd_val.push_back(read_command.address ^ DATA_KEY);
			rd_addr[read_command.tag] = read_command.address;
			rd_hits[read_command.tag]++;
			rd_total++;
		end
		if (write_command.valid) begin
			draw_delay(d);
			wr_due.push_back(now + d);
			wr_tag.push_back(write_command.tag);
			wr_addr[write_command.tag] = write_command.address;
			wr_data[write_command.tag] = write_data.data;
			wr_hits[write_command.tag]++;
			wr_total++;
		end
	endtask

	// First due entry per channel, one answer per cycle each
	task automatic deliver();
		int k;
		k = -1;
		foreach (rd_due[i])
			if (k < 0 && rd_due[i] <= now)
				k = i;
		if (k >= 0) begin
			read_response.valid = 1'b1;
			read_response.tag   = rd_tag[k];
			read_data.valid     = 1'b1;
			read_data.tag       = rd_tag[k];
			read_data.data      = rd_val[k];
			rd_due.delete(k);
			rd_tag.delete(k);
			rd_val.delete(k);
		end
		k = -1;
		foreach (wr_due[i])
			if (k < 0 && wr_due[i] <= now)
				k = i;
		if (k >= 0) begin
			write_response.valid = 1'b1;
			write_response.tag   = wr_tag[k];
			wr_due.delete(k);
			wr_tag.delete(k);
		end
	endtask

	always @(posedge clock or negedge rstn) begin
		if (!rstn)
			host_sees_enable <= 1'b0;
		else
			host_sees_enable <= enabled_in;
	end

	initial begin
		rng            = SEED;
		now            = 0;
		read_response  = '0;
		write_response = '0;
		read_data      = '0;
		clear_state();
		forever begin
			@(negedge clock);
			now++;
			read_response  = '0;
			write_response = '0;
			read_data      = '0;
			if (!rstn) begin
				clear_state();
			end else begin
				accept_commands();
				// Answers wait while the unit ignores its inputs
				if (host_sees_enable)
					deliver();
			end
		end
	end

endmodule

/* bench/cu_control_tb.sv */
`timescale 1ns/1ps
`include "cu_defs.svh"

module cu_control_tb import cu_pkg::*; ();

	localparam int          ROWS     = 5;
	localparam logic [31:0] SEED     = 32'd46;
	localparam logic [63:0] DATA_KEY = 64'h5a5a_c3c3_0f0f_9696;

	// One copy job and what it should produce
	typedef struct {
		string       name;
		int          size;
		logic [63:0] src;
		logic [63:0] dst;
		logic [63:0] cfg;
		logic [31:0] bp_mask;
		bit          drop;
		bit          expect_run;
	} test_row_t;

	test_row_t      tests [ROWS];

	logic           clock;
	logic           rstn;
	logic           enabled_in;
	logic [63:0]    cu_configure;
	wed_t           wed_request_in;
	response_t      read_response_in;
	response_t      write_response_in;
	data_line_t     read_data_in;
	buffer_status_t read_buffer_status;
	buffer_status_t write_buffer_status;
	command_t       read_command_out;
	command_t       write_command_out;
	data_line_t     write_data_out;
	logic [63:0]    cu_return;
	logic           cu_done;
	logic           cu_status;

	int             cycle;
	int             limit;
	int             row_cycle;
	int             rd_age;
	int             wr_age;
	int             test_errors;
	int             total_errors;
	int             passed;
	int             failed;
	logic [31:0]    cur_mask;
	logic [63:0]    held_return;
	bit             force_full;
	bit             zero_mode;
	bit             paused;

	always #2 clock = ~clock;

	cu_control i_dut (
		.clock               (clock),
		.rstn                (rstn),
		.enabled_in          (enabled_in),
		.cu_configure        (cu_configure),
		.wed_request_in      (wed_request_in),
		.read_response_in    (read_response_in),
		.write_response_in   (write_response_in),
		.read_data_in        (read_data_in),
		.read_buffer_status  (read_buffer_status),
		.write_buffer_status (write_buffer_status),
		.read_command_out    (read_command_out),
		.write_command_out   (write_command_out),
		.write_data_out      (write_data_out),
		.cu_return           (cu_return),
		.cu_done             (cu_done),
		.cu_status           (cu_status)
	);

	cu_memory_model #(.SEED(SEED), .DATA_KEY(DATA_KEY)) i_mem (
		.clock          (clock),
		.rstn           (rstn),
		.enabled_in     (enabled_in),
		.read_command   (read_command_out),
		.write_command  (write_command_out),
		.write_data     (write_data_out),
		.read_response  (read_response_in),
		.write_response (write_response_in),
		.read_data      (read_data_in)
	);

	//////////////////////////////
	// Test table
	//////////////////////////////

	// Mask bits 15:0 throttle reads, 31:16 writes, 8 cycles per bit
	task automatic fill_tests();
		tests[0] = '{name: "plain copy", size: 16, src: 64'h0000_0000_1000_0000,
			dst: 64'h0000_0000_2000_0000, cfg: 64'h1, bp_mask: 32'h0,
			drop: 1'b0, expect_run: 1'b1};
		tests[1] = '{name: "back-pressure", size: 64, src: 64'h0000_0040_0000_0000,
			dst: 64'h0000_0080_0000_0400, cfg: 64'h3, bp_mask: 32'h0c3c_30c6,
			drop: 1'b0, expect_run: 1'b1};
		tests[2] = '{name: "full size", size: 256, src: 64'h0001_0000_0000_0000,
			dst: 64'h0002_0000_0000_0080, cfg: 64'hdead_beef, bp_mask: 32'h00f0_0f00,
			drop: 1'b0, expect_run: 1'b1};
		tests[3] = '{name: "zero configuration", size: 32, src: 64'h0000_0000_0300_0000,
			dst: 64'h0000_0000_0400_0000, cfg: 64'h0, bp_mask: 32'h0,
			drop: 1'b0, expect_run: 1'b0};
		tests[4] = '{name: "enable drop", size: 48, src: 64'h0000_0001_0000_0000,
			dst: 64'h0000_0002_0000_0000, cfg: 64'h7, bp_mask: 32'h0,
			drop: 1'b1, expect_run: 1'b1};
	endtask

	function automatic int run_limit();
		int sum;
		sum = 0;
		for (int i = 0; i < ROWS; i++)
			sum += tests[i].size * 40 + 200;
		return sum;
	endfunction

	task automatic flag_mismatch(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		test_errors++;
	endtask

	//////////////////////////////
	// Per cycle checks and drive
	//////////////////////////////

	task automatic watch_outputs();
		if (read_command_out.valid && read_command_out.kind != CMD_READ)
			flag_mismatch("read command with wrong kind");
		if (write_command_out.valid && write_command_out.kind != CMD_WRITE)
			flag_mismatch("write command with wrong kind");
		if (write_command_out.valid !== write_data_out.valid
			|| (write_command_out.valid && write_command_out.tag !== write_data_out.tag))
			flag_mismatch("write data not paired with its command");
		if (rd_age >= 4 && read_command_out.valid)
			flag_mismatch("read command while read buffer almost full");
		if (wr_age >= 4 && write_command_out.valid)
			flag_mismatch("write command while write buffer almost full");
		if ((read_command_out.valid || write_command_out.valid) && !cu_status)
			flag_mismatch("command issued while cu_status is low");
		if (zero_mode && (read_command_out.valid || write_command_out.valid
			|| cu_status || cu_done))
			flag_mismatch("activity with zero configuration");
		if (paused && (read_command_out.valid || write_command_out.valid
			|| cu_return !== held_return))
			flag_mismatch("outputs changed while disabled");
	endtask

	task automatic tick();
		bit rd_full;
		bit wr_full;
		@(negedge clock);
		cycle++;
		row_cycle++;
		if (cycle > limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
		watch_outputs();
		rd_full = force_full || cur_mask[(row_cycle / 8) % 16];
		wr_full = force_full || cur_mask[16 + (row_cycle / 8) % 16];
		rd_age  = rd_full ? rd_age + 1 : 0;
		wr_age  = wr_full ? wr_age + 1 : 0;
		read_buffer_status.almost_full  = rd_full;
		write_buffer_status.almost_full = wr_full;
	endtask

	task automatic reset_unit();
		rstn           = 1'b0;
		enabled_in     = 1'b0;
		cu_configure   = '0;
		wed_request_in = '0;
		cur_mask       = '0;
		force_full     = 1'b0;
		zero_mode      = 1'b0;
		paused         = 1'b0;
		repeat (16) tick();
		rstn = 1'b1;
		if (cu_done !== 1'b0 || cu_status !== 1'b0 || cu_return !== '0
			|| read_command_out.valid !== 1'b0 || write_command_out.valid !== 1'b0
			|| write_data_out.valid !== 1'b0)
			flag_mismatch("outputs not zero after reset");
	endtask

	// Buffers report full up to the pause so no command is in the pipe
	task automatic pause_mid_run(input int size);
		while (i_mem.wr_total < size / 2)
			tick();
		force_full = 1'b1;
		repeat (8) tick();
		enabled_in = 1'b0;
		repeat (2) tick();
		// Buffers ready again while the engines are stopped
		force_full  = 1'b0;
		held_return = cu_return;
		paused      = 1'b1;
		repeat (20) tick();
		paused     = 1'b0;
		enabled_in = 1'b1;
	endtask

	task automatic check_completion(input test_row_t t);
		logic [63:0] src_line;
		logic [63:0] dst_line;
		if (cu_return !== {32'(t.size), 32'(t.size)})
			flag_mismatch($sformatf("cu_return %h at done, size %0d", cu_return, t.size));
		if (cu_status !== 1'b1)
			flag_mismatch("cu_status low at done");
		if (i_mem.rd_total != t.size || i_mem.wr_total != t.size)
			flag_mismatch($sformatf("%0d reads and %0d writes for %0d lines",
				i_mem.rd_total, i_mem.wr_total, t.size));
		for (int i = 0; i < t.size; i++) begin
			src_line = t.src + 64'(i) * `CU_LINE_BYTES;
			dst_line = t.dst + 64'(i) * `CU_LINE_BYTES;
			if (i_mem.rd_hits[i] != 1 || i_mem.rd_addr[i] !== src_line)
				flag_mismatch($sformatf("line %0d read %0d times at %h, expected %h",
					i, i_mem.rd_hits[i], i_mem.rd_addr[i], src_line));
			if (i_mem.wr_hits[i] != 1 || i_mem.wr_addr[i] !== dst_line
				|| i_mem.wr_data[i] !== (src_line ^ DATA_KEY))
				flag_mismatch($sformatf("line %0d wrote %h to %h, expected %h to %h",
					i, i_mem.wr_data[i], i_mem.wr_addr[i], src_line ^ DATA_KEY, dst_line));
		end
	endtask

	task automatic run_row(input int idx);
		test_row_t t;
		t           = tests[idx];
		test_errors = 0;
		reset_unit();
		row_cycle    = 0;
		cur_mask     = t.bp_mask;
		cu_configure = t.cfg;
		enabled_in   = 1'b1;
		repeat (2) tick();
		wed_request_in.valid         = 1'b1;
		wed_request_in.array_send    = t.src;
		wed_request_in.array_receive = t.dst;
		wed_request_in.size_send     = 32'(t.size);
		wed_request_in.size_receive  = 32'(t.size);
		tick();
		wed_request_in.valid = 1'b0;
		if (!t.expect_run) begin
			zero_mode = 1'b1;
			repeat (200) tick();
			zero_mode = 1'b0;
		end else begin
			if (t.drop)
				pause_mid_run(t.size);
			while (!cu_done)
				tick();
			check_completion(t);
		end
		total_errors += test_errors;
		if (test_errors == 0)
			passed++;
		else
			failed++;
		$display("test %0d %s: %s, %0d mismatches", idx, t.name,
			(test_errors == 0) ? "ok" : "wrong", test_errors);
	endtask

	initial begin
		int idx;
		clock               = 1'b0;
		rstn                = 1'b0;
		enabled_in          = 1'b0;
		cu_configure        = '0;
		wed_request_in      = '0;
		read_buffer_status  = '0;
		write_buffer_status = '0;
		cycle        = 0;
		row_cycle    = 0;
		rd_age       = 0;
		wr_age       = 0;
		total_errors = 0;
		passed       = 0;
		failed       = 0;
		fill_tests();
		limit = run_limit();
		for (idx = 0; idx < ROWS; idx++)
			run_row(idx);
		$display("tests %0d, passed %0d, failed %0d, mismatches %0d",
			ROWS, passed, failed, total_errors);
		if (failed == 0 && total_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cu_control_tb
FILELIST  ?= cu_control.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_TEXT ?= Simulation finished: FAIL
PASS_TEXT ?= Simulation finished: PASS

SOURCES := $(wildcard hw/*.sv hw/*.svh bench/*.sv)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "result: failing run"; exit 1; fi
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "result: no verdict in log"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* cu_control.f */
+incdir+hw
hw/cu_pkg.sv
hw/cu_input_stage.sv
hw/cu_read_engine.sv
hw/cu_data_fifo.sv
hw/cu_write_engine.sv
hw/cu_output_stage.sv
hw/cu_control.sv
bench/cu_memory_model.sv
bench/cu_control_tb.sv
